// ==== hdl/wadd_pkg.sv ====
// ======================================================================
// shared widths, register map, response codes and sequencer states for
// the limb-serial 64-bit add/subtract unit; imported by every module
// ======================================================================
`default_nettype none

package wadd_pkg;

   localparam int LIMB_W      = 16;
   localparam int WORD_W      = 64;
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_ADDR_W = 6;
   localparam int LIMB_IDX_W  = 2;
   localparam int NUM_LIMBS   = 4;

   typedef logic [LIMB_W-1:0]      limb_t;
   typedef logic [WORD_W-1:0]      word_t;
   typedef logic [AXIL_DATA_W-1:0] axil_data_t;
   typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
   typedef logic [LIMB_IDX_W-1:0]  limb_idx_t;

   // register byte addresses
   localparam axil_addr_t ADDR_A_LO   = 6'h00;
   localparam axil_addr_t ADDR_A_HI   = 6'h04;
   localparam axil_addr_t ADDR_B_LO   = 6'h08;
   localparam axil_addr_t ADDR_B_HI   = 6'h0C;
   localparam axil_addr_t ADDR_CTRL   = 6'h10;
   localparam axil_addr_t ADDR_STATUS = 6'h14;
   localparam axil_addr_t ADDR_RES_LO = 6'h18;
   localparam axil_addr_t ADDR_RES_HI = 6'h1C;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_RUN  = 2'd1,
      ST_DONE = 2'd2
   } wadd_state_t;

endpackage

`default_nettype wire

// ==== hdl/hc_adder_16.sv ====
// ======================================================================
// 16-bit Han-Carlson prefix adder, purely combinational
// the limb datapath chains cin/cout between limbs of a wider word
// ======================================================================
`default_nettype none

module hc_adder_16 import wadd_pkg::*; (
   input  limb_t a,
   input  limb_t b,
   input  logic  cin,
   output limb_t sum,
   output logic  cout
);

   // bit 0 carries cin as a generate, data bits sit at 1..16
   logic [LIMB_W:0]   gen;
   logic [LIMB_W:0]   prop;
   logic [7:0]        g_l1;
   logic [7:0]        p_l1;
   logic [7:0]        g_l2;
   logic [7:0]        p_l2;
   logic [7:0]        g_l3;
   logic [7:0]        p_l3;
   logic [7:0]        g_l4;
   // c[j] is the carry into bit j of the limb
   logic [LIMB_W:0]   c;

   assign gen  = {a & b, cin};
   assign prop = {a ^ b, 1'b0};

   genvar i;
   generate
      // pairwise combine of neighbouring bits
      for (i = 0; i < 8; i = i + 1) begin : g_lvl1
         assign g_l1[i] = gen[2*i+1] | (prop[2*i+1] & gen[2*i]);
         assign p_l1[i] = prop[2*i+1] & prop[2*i];
      end

      // span 1 over the pair groups
      for (i = 0; i < 8; i = i + 1) begin : g_lvl2
         if (i < 1) begin : g_pass
            assign g_l2[i] = g_l1[i];
            assign p_l2[i] = p_l1[i];
         end else begin : g_comb
            assign g_l2[i] = g_l1[i] | (p_l1[i] & g_l1[i-1]);
            assign p_l2[i] = p_l1[i] & p_l1[i-1];
         end
      end

      // span 2
      for (i = 0; i < 8; i = i + 1) begin : g_lvl3
         if (i < 2) begin : g_pass
            assign g_l3[i] = g_l2[i];
            assign p_l3[i] = p_l2[i];
         end else begin : g_comb
            assign g_l3[i] = g_l2[i] | (p_l2[i] & g_l2[i-2]);
            assign p_l3[i] = p_l2[i] & p_l2[i-2];
         end
      end

      // span 4, only generate is needed past this level
      for (i = 0; i < 8; i = i + 1) begin : g_lvl4
         if (i < 4) begin : g_pass
            assign g_l4[i] = g_l3[i];
         end else begin : g_comb
            assign g_l4[i] = g_l3[i] | (p_l3[i] & g_l3[i-4]);
         end
      end

      // prefix tree delivers carries into the odd limb bits
      for (i = 0; i < 8; i = i + 1) begin : g_odd
         assign c[2*i+1] = g_l4[i];
      end

      // one ripple stage fills in the even bits
      for (i = 1; i <= 8; i = i + 1) begin : g_even
         assign c[2*i] = gen[2*i] | (prop[2*i] & c[2*i-1]);
      end
   endgenerate

   assign c[0] = cin;

   assign sum  = prop[LIMB_W:1] ^ c[LIMB_W-1:0];
   assign cout = c[LIMB_W];

endmodule

`default_nettype wire

// ==== hdl/limb_counter.sv ====
// ======================================================================
// limb index counter, cleared at the start of an operation and stepped
// once per processed limb; last marks the final limb
// ======================================================================
`default_nettype none

module limb_counter import wadd_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      clear,
   input  logic      step,
   output limb_idx_t idx,
   output logic      last
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         idx <= '0;
      end else if (clear) begin
         idx <= '0;
      end else if (step) begin
         // wraps back to zero after the top limb
         idx <= idx + limb_idx_t'(1);
      end
   end

   assign last = (idx == limb_idx_t'(NUM_LIMBS - 1));

endmodule

`default_nettype wire

// ==== hdl/wadd_fsm.sv ====
// ======================================================================
// operation sequencer: idle, run for one cycle per limb, then done
// done stays up until the next start is taken
// ======================================================================
`default_nettype none

module wadd_fsm import wadd_pkg::*; (
   input  logic clk,
   input  logic rst_n,
   input  logic start,
   input  logic last,
   output logic clear,
   output logic step,
   output logic busy,
   output logic done
);

   wadd_state_t state;
   wadd_state_t next_state;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         state <= ST_IDLE;
      else
         state <= next_state;
   end

   always_comb begin
      next_state = state;
      case (state)
         ST_IDLE,
         ST_DONE: begin
            if (start)
               next_state = ST_RUN;
         end
         ST_RUN: begin
            // leave after the step on the top limb
            if (last)
               next_state = ST_DONE;
         end
         default: next_state = ST_IDLE;
      endcase
   end

   // a start while running is dropped
   assign clear = start & (state != ST_RUN);
   assign step  = (state == ST_RUN);
   assign busy  = (state == ST_RUN);
   assign done  = (state == ST_DONE);

endmodule

`default_nettype wire

// ==== hdl/limb_datapath.sv ====
// ======================================================================
// limb-serial datapath: picks one 16-bit limb of each operand per step,
// runs it through the prefix adder and builds the 64-bit result
// ======================================================================
`default_nettype none

module limb_datapath import wadd_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      clear,
   input  logic      step,
   input  logic      sub,
   input  limb_idx_t idx,
   input  word_t     op_a,
   input  word_t     op_b,
   output word_t     result,
   output logic      carry
);

   limb_t limb_a;
   limb_t limb_b;
   limb_t limb_sum;
   logic  limb_cout;

   assign limb_a = op_a[idx*LIMB_W +: LIMB_W];
   // subtract is A + ~B + 1, the +1 comes in through the carry register
   assign limb_b = op_b[idx*LIMB_W +: LIMB_W] ^ {LIMB_W{sub}};

   hc_adder_16 u_adder (
      .a    (limb_a),
      .b    (limb_b),
      .cin  (carry),
      .sum  (limb_sum),
      .cout (limb_cout)
   );

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         carry <= 1'b0;
      end else if (clear) begin
         carry <= sub;
      end else if (step) begin
         carry <= limb_cout;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         result <= '0;
      end else if (step) begin
         result[idx*LIMB_W +: LIMB_W] <= limb_sum;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/wadd_regs.sv ====
// ======================================================================
// AXI4-Lite slave for the add/subtract unit with the operand, control,
// status and result registers
// a CTRL write with bit0 set issues a start pulse
// ======================================================================
`default_nettype none

module wadd_regs import wadd_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  axil_addr_t awaddr,
   input  logic       awvalid,
   output logic       awready,
   input  axil_data_t wdata,
   input  logic [3:0] wstrb,
   input  logic       wvalid,
   output logic       wready,
   output logic [1:0] bresp,
   output logic       bvalid,
   input  logic       bready,
   input  axil_addr_t araddr,
   input  logic       arvalid,
   output logic       arready,
   output axil_data_t rdata,
   output logic [1:0] rresp,
   output logic       rvalid,
   input  logic       rready,
   output word_t      op_a,
   output word_t      op_b,
   output logic       sub,
   output logic       start,
   input  logic       busy,
   input  logic       done,
   input  word_t      result,
   input  logic       carry
);

   logic       aw_go;
   logic       wr_en;
   logic       wr_hit;
   logic       start_wr;
   logic       rd_en;
   logic       rd_hit;
   axil_data_t rd_word;
   logic       busy_s;
   logic       done_s;

   function automatic axil_data_t apply_strb(input axil_data_t old_val,
                                             input axil_data_t new_val,
                                             input logic [3:0] strb);
      axil_data_t merged;
      merged = old_val;
      for (int k = 0; k < 4; k++) begin
         if (strb[k])
            merged[8*k +: 8] = new_val[8*k +: 8];
      end
      return merged;
   endfunction

   // both channels accepted together with a one-cycle ready pulse
   assign aw_go = awvalid & wvalid & ~awready & ~bvalid;
   assign wr_en = awready & awvalid & wvalid;

   assign wr_hit = (awaddr inside {ADDR_A_LO, ADDR_A_HI, ADDR_B_LO, ADDR_B_HI,
                                   ADDR_CTRL, ADDR_STATUS, ADDR_RES_LO, ADDR_RES_HI});

   assign start_wr = wr_en & (awaddr == ADDR_CTRL) & wstrb[0] & wdata[0] & ~busy;

   // pending start already counts as busy to the host
   assign busy_s = busy | start;
   assign done_s = done & ~start;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         bresp   <= RESP_OKAY;
      end else begin
         awready <= aw_go;
         wready  <= aw_go;
         if (wr_en) begin
            bvalid <= 1'b1;
            bresp  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         op_a  <= '0;
         op_b  <= '0;
         sub   <= 1'b0;
         start <= 1'b0;
      end else begin
         start <= start_wr;
         if (start_wr)
            sub <= wdata[1];
         if (wr_en) begin
            case (awaddr)
               ADDR_A_LO: op_a[31:0]  <= apply_strb(op_a[31:0], wdata, wstrb);
               ADDR_A_HI: op_a[63:32] <= apply_strb(op_a[63:32], wdata, wstrb);
               ADDR_B_LO: op_b[31:0]  <= apply_strb(op_b[31:0], wdata, wstrb);
               ADDR_B_HI: op_b[63:32] <= apply_strb(op_b[63:32], wdata, wstrb);
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      rd_hit  = 1'b1;
      rd_word = '0;
      case (araddr)
         ADDR_A_LO:   rd_word = op_a[31:0];
         ADDR_A_HI:   rd_word = op_a[63:32];
         ADDR_B_LO:   rd_word = op_b[31:0];
         ADDR_B_HI:   rd_word = op_b[63:32];
         ADDR_CTRL:   rd_word = {30'd0, sub, 1'b0};
         ADDR_STATUS: rd_word = {29'd0, carry, done_s, busy_s};
         ADDR_RES_LO: rd_word = result[31:0];
         ADDR_RES_HI: rd_word = result[63:32];
         default:     rd_hit  = 1'b0;
      endcase
   end

   assign rd_en = arready & arvalid;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
         rdata   <= '0;
         rresp   <= RESP_OKAY;
      end else begin
         arready <= arvalid & ~arready & ~rvalid;
         if (rd_en) begin
            rvalid <= 1'b1;
            rdata  <= rd_word;
            rresp  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/wadd_top.sv ====
// ======================================================================
// top level of the 64-bit add/subtract unit, reached only over the
// AXI4-Lite slave ports
// ======================================================================
`default_nettype none

module wadd_top import wadd_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  axil_addr_t awaddr,
   input  logic       awvalid,
   output logic       awready,
   input  axil_data_t wdata,
   input  logic [3:0] wstrb,
   input  logic       wvalid,
   output logic       wready,
   output logic [1:0] bresp,
   output logic       bvalid,
   input  logic       bready,
   input  axil_addr_t araddr,
   input  logic       arvalid,
   output logic       arready,
   output axil_data_t rdata,
   output logic [1:0] rresp,
   output logic       rvalid,
   input  logic       rready
);

   word_t     op_a;
   word_t     op_b;
   word_t     result;
   logic      sub;
   logic      start;
   logic      busy;
   logic      done;
   logic      carry;
   logic      clear;
   logic      step;
   logic      last;
   limb_idx_t idx;

   // port names line up with the nets above
   wadd_regs     u_regs     (.*);
   wadd_fsm      u_fsm      (.*);
   limb_counter  u_counter  (.*);
   limb_datapath u_datapath (.*);

endmodule

`default_nettype wire

// ==== verification/wadd_tb.sv ====
// ======================================================================
// testbench for the 64-bit add/subtract unit that drives the AXI4-Lite
// port, replays the operation trace, adds seeded random sums and checks
// register readback and unmapped-address responses
// ======================================================================
`default_nettype none

module wadd_tb import wadd_pkg::*; ();

   localparam int TIMEOUT_CYCLES = 50;
   localparam int POLL_LIMIT     = 20;

   logic       clk = 1'b0;
   logic       rst_n;
   axil_addr_t awaddr;
   logic       awvalid;
   logic       awready;
   axil_data_t wdata;
   logic [3:0] wstrb;
   logic       wvalid;
   logic       wready;
   logic [1:0] bresp;
   logic       bvalid;
   logic       bready;
   axil_addr_t araddr;
   logic       arvalid;
   logic       arready;
   axil_data_t rdata;
   logic [1:0] rresp;
   logic       rvalid;
   logic       rready;

   int error_count = 0;
   int test_count  = 0;
   int fail_count  = 0;
   int test_errors = 0;
   int seed        = 34834;

   wadd_top u_dut (.*);

   always #50 clk = ~clk;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TB FAILED");
      $finish;
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_carry(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic check_data(input string name, input axil_data_t got, input axil_data_t exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic finish_test(input string name);
      test_count++;
      if (error_count != test_errors) begin
         fail_count++;
         $display("test %0d %s: fail", test_count, name);
      end else begin
         $display("test %0d %s: ok", test_count, name);
      end
      test_errors = error_count;
   endtask

   task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                             input logic [3:0] strb, output logic [1:0] resp);
      int wait_cnt;
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wstrb   <= strb;
      wvalid  <= 1'b1;
      bready  <= 1'b1;
      wait_cnt = 0;
      @(negedge clk);
      while (!(awready && wready)) begin
         if (wait_cnt == TIMEOUT_CYCLES)
            abort_run("write address and data were never accepted");
         wait_cnt++;
         @(negedge clk);
      end
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      wait_cnt = 0;
      @(negedge clk);
      while (!bvalid) begin
         if (wait_cnt == TIMEOUT_CYCLES)
            abort_run("write response never arrived");
         wait_cnt++;
         @(negedge clk);
      end
      resp = bresp;
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                            output logic [1:0] resp);
      int wait_cnt;
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      rready  <= 1'b1;
      wait_cnt = 0;
      @(negedge clk);
      while (!arready) begin
         if (wait_cnt == TIMEOUT_CYCLES)
            abort_run("read address was never accepted");
         wait_cnt++;
         @(negedge clk);
      end
      @(posedge clk);
      arvalid <= 1'b0;
      wait_cnt = 0;
      @(negedge clk);
      while (!rvalid) begin
         if (wait_cnt == TIMEOUT_CYCLES)
            abort_run("read data never arrived");
         wait_cnt++;
         @(negedge clk);
      end
      data = rdata;
      resp = rresp;
      @(posedge clk);
      rready <= 1'b0;
   endtask

   task automatic write_okay(input axil_addr_t addr, input axil_data_t data);
      logic [1:0] resp;
      axil_write(addr, data, 4'hF, resp);
      check_resp("bresp", resp, RESP_OKAY);
   endtask

   task automatic run_op(input logic sub_op, input word_t a, input word_t b,
                         output word_t res, output logic c);
      logic [1:0] resp;
      axil_data_t status;
      axil_data_t lo;
      axil_data_t hi;
      int         polls;
      write_okay(ADDR_A_LO, a[31:0]);
      write_okay(ADDR_A_HI, a[63:32]);
      write_okay(ADDR_B_LO, b[31:0]);
      write_okay(ADDR_B_HI, b[63:32]);
      write_okay(ADDR_CTRL, {30'd0, sub_op, 1'b1});
      // limbs still in flight so busy is up and done is low
      axil_read(ADDR_STATUS, status, resp);
      check_data("status busy/done after start", {30'd0, status[1:0]}, 32'h1);
      polls = 0;
      while (!status[1]) begin
         if (polls == POLL_LIMIT)
            abort_run("status never reported the operation as done");
         polls++;
         axil_read(ADDR_STATUS, status, resp);
      end
      check_data("status busy/done", {30'd0, status[1:0]}, 32'h2);
      c = status[2];
      axil_read(ADDR_RES_LO, lo, resp);
      check_resp("rresp RES_LO", resp, RESP_OKAY);
      axil_read(ADDR_RES_HI, hi, resp);
      check_resp("rresp RES_HI", resp, RESP_OKAY);
      res = {hi, lo};
   endtask

   initial begin
      string           line;
      int              fd;
      int              fields;
      int              line_no;
      logic [3:0]      op_code;
      word_t           a;
      word_t           b;
      word_t           exp_res;
      logic            exp_c;
      word_t           got_res;
      logic            got_c;
      axil_data_t      rd;
      logic [1:0]      resp;
      logic [WORD_W:0] full_sum;

      rst_n   <= 1'b0;
      awaddr  <= '0;
      awvalid <= 1'b0;
      wdata   <= '0;
      wstrb   <= '0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
      araddr  <= '0;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      for (int k = 0; k < 4; k++)
         write_okay(axil_addr_t'(4 * k), 32'h5A5A_0000 + 32'h1111 * k);
      for (int k = 0; k < 4; k++) begin
         axil_read(axil_addr_t'(4 * k), rd, resp);
         check_resp("rresp operand", resp, RESP_OKAY);
         check_data("operand readback", rd, 32'h5A5A_0000 + 32'h1111 * k);
      end
      finish_test("operand readback");

      fd = $fopen("verification/wadd_trace.txt", "r");
      if (fd == 0)
         abort_run("could not open the trace file");
      line_no = 0;
      while ($fgets(line, fd) != 0) begin
         line_no++;
         // comment and blank lines yield no fields
         fields = $sscanf(line, "%h %h %h %h %h", op_code, a, b, exp_res, exp_c);
         if (fields == 5) begin
            run_op(op_code[0], a, b, got_res, got_c);
            check_word("result", got_res, exp_res);
            check_carry("carry", got_c, exp_c);
            finish_test($sformatf("trace line %0d %s", line_no, op_code[0] ? "sub" : "add"));
         end
      end
      $fclose(fd);

      for (int n = 0; n < 8; n++) begin
         a = {$random(seed), $random(seed)};
         b = {$random(seed), $random(seed)};
         full_sum = {1'b0, a} + {1'b0, b};
         run_op(1'b0, a, b, got_res, got_c);
         check_word("result", got_res, full_sum[WORD_W-1:0]);
         check_carry("carry", got_c, full_sum[WORD_W]);
         finish_test($sformatf("random add %0d", n));
      end

      axil_write(6'h20, 32'hDEAD_BEEF, 4'hF, resp);
      check_resp("bresp unmapped", resp, RESP_SLVERR);
      axil_read(6'h24, rd, resp);
      check_resp("rresp unmapped", resp, RESP_SLVERR);
      check_data("rdata unmapped", rd, '0);
      axil_read(6'h3C, rd, resp);
      check_resp("rresp unmapped", resp, RESP_SLVERR);
      check_data("rdata unmapped", rd, '0);
      finish_test("unmapped address");

      $display("tests %0d, failed %0d, errors %0d", test_count, fail_count, error_count);
      if (error_count == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verification/wadd_trace.txt ====
# columns: op a b expected_result expected_carry, all in hex
# op 0 adds, op 1 subtracts; carry on subtract is the inverted borrow
0 0000000000000001 0000000000000002 0000000000000003 0
0 FFFFFFFFFFFFFFFF 0000000000000001 0000000000000000 1
0 0000FFFFFFFFFFFF 0000000000000001 0001000000000000 0
0 000000000000FFFF 0000000000000001 0000000000010000 0
0 00000000FFFFFFFF 0000000000000001 0000000100000000 0
0 8000000000000000 8000000000000000 0000000000000000 1
0 123456789ABCDEF0 0FEDCBA987654321 2222222222222211 0
0 FFFF0000FFFF0000 0001FFFF0001FFFF 000100000000FFFF 1
1 0000000000000005 0000000000000003 0000000000000002 1
1 0000000000000003 0000000000000005 FFFFFFFFFFFFFFFE 0
1 0000000000000000 0000000000000000 0000000000000000 1
1 0000000000000000 0000000000000001 FFFFFFFFFFFFFFFF 0
1 0001000000000000 0000000000000001 0000FFFFFFFFFFFF 1
1 123456789ABCDEF0 123456789ABCDEF0 0000000000000000 1
1 8000000000000000 7FFFFFFFFFFFFFFF 0000000000000001 1
1 0000000000010000 0000000000000001 000000000000FFFF 1

// ==== vlog.f ====
hdl/wadd_pkg.sv
hdl/hc_adder_16.sv
hdl/limb_counter.sv
hdl/wadd_fsm.sv
hdl/limb_datapath.sv
hdl/wadd_regs.sv
hdl/wadd_top.sv
verification/wadd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module wadd_tb -o wadd_sim

sim_out=$(./obj_dir/wadd_sim)
echo "$sim_out"
echo "$sim_out" | grep -q -x "TB PASSED"
